// ==== hw/ppi_consts.svh ====
// PPI register map and encodings
`ifndef PPI_CONSTS_SVH
`define PPI_CONSTS_SVH

// APB address width in bits
`define PPI_ADDR_WIDTH 4

// Register byte offsets
`define PPI_REG_PORT_A  4'h0
`define PPI_REG_PORT_B  4'h4
`define PPI_REG_CONTROL 4'h8
`define PPI_REG_STATUS  4'hc

// Port direction
`define PPI_DIR_INPUT  1'b1
`define PPI_DIR_OUTPUT 1'b0

// Control word layout
`define PPI_CTL_WIDTH  4
`define PPI_CTL_A_MODE 0
`define PPI_CTL_A_DIR  1
`define PPI_CTL_B_MODE 2
`define PPI_CTL_B_DIR  3

// Status word layout
`define PPI_STS_IBF_A 0
`define PPI_STS_IBF_B 1

`endif

// ==== hw/ppi_pkg.sv ====
// PPI shared types
`include "ppi_consts.svh"

package ppi_pkg;

    // APB address and data
    typedef logic [`PPI_ADDR_WIDTH-1:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Port payloads
    typedef logic [7:0] port_a_t;
    typedef logic [3:0] port_b_t;

    // Port operating mode
    typedef enum logic {
        MODE_STROBED_OFF = 1'b0,
        MODE_STROBED_IN  = 1'b1
    } port_mode_t;

endpackage

// ==== hw/ppi_port.sv ====
// Parallel I/O port
`timescale 1ns/10ps
`include "ppi_consts.svh"

module ppi_port #(
    parameter type data_t = logic [7:0]
) (
    input  logic                reset,
    input  logic                clock,

    // From the register block
    input  data_t               wdata,
    input  logic                write_port,
    input  logic                read_port,
    input  logic                update_mode,
    input  ppi_pkg::port_mode_t port_mode,
    input  logic                port_dir,

    // Pins
    input  logic                strobe,
    input  data_t               port_in,
    output logic                port_io,
    output data_t               port_out,

    // To the register block
    output data_t               read,
    output logic                ibf
);

    import ppi_pkg::*;

    data_t in_latch;

    // Direction from the control field
    always_ff @(posedge reset or posedge clock) begin
        if (clock) begin
            port_io <= `PPI_DIR_OUTPUT;
        end else begin
            port_io <= port_dir;
        end
    end

    // Output latch
    always_ff @(posedge reset or posedge clock) begin
        if (clock) begin
            port_out <= '0;
        end else if (update_mode) begin
            port_out <= '0;
        end else if (write_port) begin
            port_out <= wdata;
        end
    end

    // Input latch free running in mode 0 and strobed in mode 1
    always_ff @(posedge reset or posedge clock) begin
        if (clock) begin
            in_latch <= '0;
        end else if (update_mode) begin
            in_latch <= '0;
        end else if (port_mode == MODE_STROBED_OFF) begin
            in_latch <= port_in;
        end else if (strobe) begin
            in_latch <= port_in;
        end
    end

    // Buffer full flag where a strobe beats a read at the same edge
    always_ff @(posedge reset or posedge clock) begin
        if (clock) begin
            ibf <= 1'b0;
        end else if (update_mode) begin
            ibf <= 1'b0;
        end else if (port_mode == MODE_STROBED_IN) begin
            if (strobe) begin
                ibf <= 1'b1;
            end else if (read_port) begin
                ibf <= 1'b0;
            end
        end else begin
            ibf <= 1'b0;
        end
    end

    assign read = (port_io == `PPI_DIR_INPUT) ? in_latch : port_out;

    // Register block never writes data and control in one access
    a_write_vs_mode: assert property (
        @(posedge reset) disable iff (clock)
        !(write_port && update_mode)
    );

endmodule

// ==== hw/ppi_apb_regs.sv ====
// PPI APB register block
`timescale 1ns/10ps
`include "ppi_consts.svh"

module ppi_apb_regs (
    input  logic                reset,
    input  logic                clock,

    // APB slave
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  ppi_pkg::apb_addr_t  paddr,
    input  ppi_pkg::apb_data_t  pwdata,
    output ppi_pkg::apb_data_t  prdata,
    output logic                pready,
    output logic                pslverr,

    // From the ports
    input  ppi_pkg::port_a_t    port_a_read,
    input  ppi_pkg::port_b_t    port_b_read,
    input  logic                ibf_a,
    input  logic                ibf_b,

    // Control fields
    output ppi_pkg::port_mode_t a_mode,
    output logic                a_dir,
    output ppi_pkg::port_mode_t b_mode,
    output logic                b_dir,

    // Access pulses
    output logic                write_a,
    output logic                write_b,
    output logic                read_a,
    output logic                read_b,
    output logic                update_mode
);

    import ppi_pkg::*;

    logic                      access;
    logic                      access_ok;
    logic                      bad_addr;
    logic                      bad_write;
    apb_addr_t                 word_addr;
    logic [`PPI_CTL_WIDTH-1:0] ctl_q;
    logic [`PPI_CTL_WIDTH-1:0] ctl_next;
    apb_data_t                 status;

    // Access phase is never stalled
    assign access = psel & penable;
    assign pready = access;

    // Byte offsets inside a word alias to that word
    assign word_addr = {paddr[`PPI_ADDR_WIDTH-1:2], 2'b00};

    assign bad_addr  = (paddr > `PPI_REG_STATUS);
    assign bad_write = pwrite & (word_addr == `PPI_REG_STATUS);
    assign pslverr   = access & (bad_addr | bad_write);
    assign access_ok = access & ~bad_addr & ~bad_write;

    // Per-register pulses
    assign write_a     = access_ok & pwrite & (word_addr == `PPI_REG_PORT_A);
    assign write_b     = access_ok & pwrite & (word_addr == `PPI_REG_PORT_B);
    assign update_mode = access_ok & pwrite & (word_addr == `PPI_REG_CONTROL);
    assign read_a      = access_ok & ~pwrite & (word_addr == `PPI_REG_PORT_A);
    assign read_b      = access_ok & ~pwrite & (word_addr == `PPI_REG_PORT_B);

    // Control register
    assign ctl_next = update_mode ? pwdata[`PPI_CTL_WIDTH-1:0] : ctl_q;

    always_ff @(posedge reset or posedge clock) begin
        if (clock) begin
            ctl_q <= '0;
        end else begin
            ctl_q <= ctl_next;
        end
    end

    // Fields pass a control write through so the ports switch at the same edge
    assign a_mode = port_mode_t'(ctl_next[`PPI_CTL_A_MODE]);
    assign a_dir  = ctl_next[`PPI_CTL_A_DIR];
    assign b_mode = port_mode_t'(ctl_next[`PPI_CTL_B_MODE]);
    assign b_dir  = ctl_next[`PPI_CTL_B_DIR];

    // Status word
    always_comb begin
        status = '0;
        status[`PPI_STS_IBF_A] = ibf_a;
        status[`PPI_STS_IBF_B] = ibf_b;
    end

    // Read data is zero outside a legal read
    always_comb begin
        prdata = '0;
        if (access_ok && !pwrite) begin
            case (word_addr)
                `PPI_REG_PORT_A:  prdata = apb_data_t'(port_a_read);
                `PPI_REG_PORT_B:  prdata = apb_data_t'(port_b_read);
                `PPI_REG_CONTROL: prdata = apb_data_t'(ctl_q);
                `PPI_REG_STATUS:  prdata = status;
                default:          prdata = '0;
            endcase
        end
    end

    // Bus master keeps psel through the access phase
    a_penable_psel: assert property (
        @(posedge reset) disable iff (clock)
        penable |-> psel
    );

endmodule

// ==== hw/ppi_top.sv ====
// PPI top level
`timescale 1ns/10ps

module ppi_top (
    input  logic               reset,
    input  logic               clock,

    // APB slave
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  ppi_pkg::apb_addr_t paddr,
    input  ppi_pkg::apb_data_t pwdata,
    output ppi_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr,

    // Port A pins
    input  ppi_pkg::port_a_t   port_a_in,
    input  logic               port_a_stb,
    output ppi_pkg::port_a_t   port_a_out,
    output logic               port_a_io,

    // Port B pins
    input  ppi_pkg::port_b_t   port_b_in,
    input  logic               port_b_stb,
    output ppi_pkg::port_b_t   port_b_out,
    output logic               port_b_io
);

    import ppi_pkg::*;

    port_mode_t a_mode;
    port_mode_t b_mode;
    logic       a_dir;
    logic       b_dir;
    logic       write_a;
    logic       write_b;
    logic       read_a;
    logic       read_b;
    logic       update_mode;
    port_a_t    port_a_read;
    port_b_t    port_b_read;
    logic       ibf_a;
    logic       ibf_b;

    ppi_apb_regs regs_i (
        .reset       (reset),
        .clock       (clock),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .port_a_read (port_a_read),
        .port_b_read (port_b_read),
        .ibf_a       (ibf_a),
        .ibf_b       (ibf_b),
        .a_mode      (a_mode),
        .a_dir       (a_dir),
        .b_mode      (b_mode),
        .b_dir       (b_dir),
        .write_a     (write_a),
        .write_b     (write_b),
        .read_a      (read_a),
        .read_b      (read_b),
        .update_mode (update_mode)
    );

    // 8-bit port
    ppi_port #(
        .data_t (port_a_t)
    ) port_a_i (
        .reset       (reset),
        .clock       (clock),
        .wdata       (port_a_t'(pwdata)),
        .write_port  (write_a),
        .read_port   (read_a),
        .update_mode (update_mode),
        .port_mode   (a_mode),
        .port_dir    (a_dir),
        .strobe      (port_a_stb),
        .port_in     (port_a_in),
        .port_io     (port_a_io),
        .port_out    (port_a_out),
        .read        (port_a_read),
        .ibf         (ibf_a)
    );

    // 4-bit port keeps the low nibble of a write
    ppi_port #(
        .data_t (port_b_t)
    ) port_b_i (
        .reset       (reset),
        .clock       (clock),
        .wdata       (port_b_t'(pwdata)),
        .write_port  (write_b),
        .read_port   (read_b),
        .update_mode (update_mode),
        .port_mode   (b_mode),
        .port_dir    (b_dir),
        .strobe      (port_b_stb),
        .port_in     (port_b_in),
        .port_io     (port_b_io),
        .port_out    (port_b_out),
        .read        (port_b_read),
        .ibf         (ibf_b)
    );

endmodule

// ==== tests/tb_clock_gen.sv ====
// Testbench clock and reset
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 3
) (
    output logic reset,
    output logic clock
);

    // Free running clock on the reset line
    initial begin
        reset = 1'b0;
        forever begin
            #(period_ns / 2);
            reset = ~reset;
        end
    end

    // Active-high reset on the clock line for the first rising edges
    initial begin
        clock = 1'b1;
        repeat (reset_cycles) @(posedge reset);
        clock <= 1'b0;
    end

endmodule

// ==== tests/ppi_tb.sv ====
// PPI testbench
`timescale 1ns/10ps
`include "ppi_consts.svh"

module ppi_tb;

    import ppi_pkg::*;

    localparam int unsigned seed       = 32'hfe2b71bd;
    localparam int          num_trans  = 400;
    // Up to four cycles per transfer plus room for the directed part
    localparam int          timeout_ns = num_trans * 4 * 8 + 2000;

    logic      reset;
    logic      clock;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    port_a_t   port_a_in;
    logic      port_a_stb;
    port_a_t   port_a_out;
    logic      port_a_io;
    port_b_t   port_b_in;
    logic      port_b_stb;
    port_b_t   port_b_out;
    logic      port_b_io;

    // Reference model
    logic [`PPI_CTL_WIDTH-1:0] mdl_ctl;
    port_a_t                   mdl_out_a;
    port_a_t                   mdl_in_a;
    port_b_t                   mdl_out_b;
    port_b_t                   mdl_in_b;
    logic                      mdl_ibf_a;
    logic                      mdl_ibf_b;

    tb_clock_gen clk_gen_i (
        .reset (reset),
        .clock (clock)
    );

    ppi_top ppi_top_i (
        .reset      (reset),
        .clock      (clock),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .port_a_in  (port_a_in),
        .port_a_stb (port_a_stb),
        .port_a_out (port_a_out),
        .port_a_io  (port_a_io),
        .port_b_in  (port_b_in),
        .port_b_stb (port_b_stb),
        .port_b_out (port_b_out),
        .port_b_io  (port_b_io)
    );

    task automatic check_data(input string name, input apb_data_t exp, input apb_data_t act);
        if (act !== exp) begin
            $display("ERROR at %0t: %s expected %h actual %h", $time, name, exp, act);
            $display("tests failed");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_port_a(input string name, input port_a_t exp, input port_a_t act);
        if (act !== exp) begin
            $display("ERROR at %0t: %s expected %h actual %h", $time, name, exp, act);
            $display("tests failed");
            $fatal(1, "port A mismatch");
        end
    endtask

    task automatic check_port_b(input string name, input port_b_t exp, input port_b_t act);
        if (act !== exp) begin
            $display("ERROR at %0t: %s expected %h actual %h", $time, name, exp, act);
            $display("tests failed");
            $fatal(1, "port B mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR at %0t: %s expected %b actual %b", $time, name, exp, act);
            $display("tests failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    // Byte offsets inside a register word select that word
    function automatic apb_addr_t word_of(input apb_addr_t addr);
        return {addr[`PPI_ADDR_WIDTH-1:2], 2'b00};
    endfunction

    function automatic logic legal(input logic wr, input apb_addr_t addr);
        return !(addr > `PPI_REG_STATUS) && !(wr && word_of(addr) == `PPI_REG_STATUS);
    endfunction

    task automatic compare_outputs();
        logic      access;
        apb_data_t exp_rdata;
        access = psel & penable;
        exp_rdata = '0;
        if (access && !pwrite && legal(pwrite, paddr)) begin
            case (word_of(paddr))
                `PPI_REG_PORT_A: begin
                    exp_rdata[7:0] = mdl_ctl[`PPI_CTL_A_DIR] ? mdl_in_a : mdl_out_a;
                end
                `PPI_REG_PORT_B: begin
                    exp_rdata[3:0] = mdl_ctl[`PPI_CTL_B_DIR] ? mdl_in_b : mdl_out_b;
                end
                `PPI_REG_CONTROL: exp_rdata[`PPI_CTL_WIDTH-1:0] = mdl_ctl;
                `PPI_REG_STATUS: begin
                    exp_rdata[`PPI_STS_IBF_A] = mdl_ibf_a;
                    exp_rdata[`PPI_STS_IBF_B] = mdl_ibf_b;
                end
                default: exp_rdata = '0;
            endcase
        end
        check_bit("pready", access, pready);
        check_bit("pslverr", access && !legal(pwrite, paddr), pslverr);
        check_data("prdata", exp_rdata, prdata);
        check_port_a("port_a_out", mdl_out_a, port_a_out);
        check_port_b("port_b_out", mdl_out_b, port_b_out);
        check_bit("port_a_io", mdl_ctl[`PPI_CTL_A_DIR], port_a_io);
        check_bit("port_b_io", mdl_ctl[`PPI_CTL_B_DIR], port_b_io);
    endtask

    // Model state at the coming rising edge
    task automatic advance_model();
        logic      ok;
        apb_addr_t word;
        ok = psel && penable && legal(pwrite, paddr);
        word = word_of(paddr);
        if (ok && pwrite && word == `PPI_REG_CONTROL) begin
            mdl_ctl = pwdata[`PPI_CTL_WIDTH-1:0];
            mdl_out_a = '0;
            mdl_out_b = '0;
            mdl_in_a = '0;
            mdl_in_b = '0;
            mdl_ibf_a = 1'b0;
            mdl_ibf_b = 1'b0;
        end else begin
            if (ok && pwrite && word == `PPI_REG_PORT_A) begin
                mdl_out_a = port_a_t'(pwdata);
            end
            if (ok && pwrite && word == `PPI_REG_PORT_B) begin
                mdl_out_b = port_b_t'(pwdata);
            end
            if (port_mode_t'(mdl_ctl[`PPI_CTL_A_MODE]) == MODE_STROBED_OFF) begin
                mdl_in_a = port_a_in;
            end else if (port_a_stb) begin
                mdl_in_a = port_a_in;
                mdl_ibf_a = 1'b1;
            end else if (ok && !pwrite && word == `PPI_REG_PORT_A) begin
                mdl_ibf_a = 1'b0;
            end
            if (port_mode_t'(mdl_ctl[`PPI_CTL_B_MODE]) == MODE_STROBED_OFF) begin
                mdl_in_b = port_b_in;
            end else if (port_b_stb) begin
                mdl_in_b = port_b_in;
                mdl_ibf_b = 1'b1;
            end else if (ok && !pwrite && word == `PPI_REG_PORT_B) begin
                mdl_ibf_b = 1'b0;
            end
        end
    endtask

    // One clock with random pin activity
    task automatic run_cycle(input logic sel, input logic en, input logic wr,
                             input apb_addr_t addr, input apb_data_t data);
        logic [31:0] rnd;
        @(posedge reset);
        rnd = $urandom;
        psel <= sel;
        penable <= en;
        pwrite <= wr;
        paddr <= addr;
        pwdata <= data;
        if (rnd[0]) begin
            port_a_in <= rnd[15:8];
        end
        if (rnd[1]) begin
            port_b_in <= rnd[19:16];
        end
        port_a_stb <= (rnd[3:2] == 2'b00);
        port_b_stb <= (rnd[5:4] == 2'b00);
        @(negedge reset);
        compare_outputs();
        advance_model();
    endtask

    task automatic idle_cycle();
        logic [31:0] rnd;
        rnd = $urandom;
        run_cycle(1'b0, 1'b0, rnd[4], rnd[3:0], $urandom);
    endtask

    task automatic apb_transfer(input logic wr, input apb_addr_t addr, input apb_data_t data);
        run_cycle(1'b1, 1'b0, wr, addr, data);
        run_cycle(1'b1, 1'b1, wr, addr, data);
    endtask

    initial begin
        #(timeout_ns);
        $display("Timeout: the run did not finish within %0d ns", timeout_ns);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] rnd;
        apb_addr_t   addr;
        rnd = $urandom(seed);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        port_a_in = '0;
        port_a_stb = 1'b0;
        port_b_in = '0;
        port_b_stb = 1'b0;
        mdl_ctl = '0;
        mdl_out_a = '0;
        mdl_in_a = '0;
        mdl_out_b = '0;
        mdl_in_b = '0;
        mdl_ibf_a = 1'b0;
        mdl_ibf_b = 1'b0;
        @(negedge clock);
        idle_cycle();

        // Directed pass over each register
        apb_transfer(1'b1, `PPI_REG_PORT_A, 32'h0000_00a5);
        apb_transfer(1'b1, `PPI_REG_PORT_B, 32'h0000_003c);
        apb_transfer(1'b0, `PPI_REG_PORT_A, '0);
        apb_transfer(1'b0, `PPI_REG_PORT_B, '0);
        apb_transfer(1'b1, `PPI_REG_CONTROL, 32'h0000_000a);
        apb_transfer(1'b0, `PPI_REG_CONTROL, '0);
        idle_cycle();
        apb_transfer(1'b0, `PPI_REG_PORT_A, '0);
        apb_transfer(1'b0, `PPI_REG_PORT_B, '0);
        apb_transfer(1'b1, `PPI_REG_CONTROL, 32'h0000_000f);
        idle_cycle();
        apb_transfer(1'b0, `PPI_REG_STATUS, '0);
        apb_transfer(1'b0, `PPI_REG_PORT_A, '0);
        apb_transfer(1'b0, `PPI_REG_STATUS, '0);
        apb_transfer(1'b1, `PPI_REG_STATUS, 32'h0000_0003);
        apb_transfer(1'b0, 4'hd, '0);
        apb_transfer(1'b1, 4'hf, 32'hffff_ffff);

        // Random transfers with a quarter of them at any address
        for (int i = 0; i < num_trans; i++) begin
            rnd = $urandom;
            if (rnd[3:0] < 4'd4) begin
                addr = rnd[7:4];
            end else begin
                addr = {rnd[9:8], 2'b00};
            end
            apb_transfer(rnd[10], addr, $urandom);
            if (rnd[11]) begin
                idle_cycle();
            end
            if (rnd[12]) begin
                idle_cycle();
            end
        end

        idle_cycle();
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+hw
hw/ppi_pkg.sv
hw/ppi_port.sv
hw/ppi_apb_regs.sv
hw/ppi_top.sv
tests/tb_clock_gen.sv
tests/ppi_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the PPI testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module ppi_tb -f verilog.f \
    && ./obj_dir/Vppi_tb > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "tests failed" sim.log 2>/dev/null && { echo "Simulation FAILED"; exit 1; }
grep -q "all tests passed" sim.log 2>/dev/null || { echo "Simulation did not complete"; exit 1; }

echo "Simulation PASSED"
exit 0
